// ==== Bender.yml ====
package:
  name: cal_telemetry

sources:
  - files:
      - verilog/cal_telemetry_pkg.sv
      - verilog/uart_tx.sv
      - verilog/cal_frame_sequencer.sv
      - verilog/cal_telemetry_top.sv
  - target: test
    files:
      - bench/uart_rx_model.sv
      - bench/cal_telemetry_tb.sv

// ==== bench/cal_telemetry_tb.sv ====
// ##################################################
// Directed testbench for the telemetry stream
// Decodes tx with a UART model and checks frame bytes
// ##################################################

module cal_telemetry_tb
    import cal_telemetry_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int          CLK_PERIOD = 100;
    localparam int          DRIVE_DLY  = 10;
    localparam int          BYTE_CLKS  = UART_BITS * CLKS_PER_BIT;
    localparam logic [31:0] LFSR_TAPS  = 32'h80200003;

    logic                       clk;
    logic                       rst;
    logic [7:0]                 eeprom_mfg;
    logic [7:0]                 eeprom_dev;
    logic [31:0]                eeprom_serial;
    logic [7:0]                 jack;
    logic signed [SAMPLE_W-1:0] adc [NUM_CH];
    logic signed [SAMPLE_W-1:0] dac [NUM_CH];
    logic                       tx;

    logic [31:0] lfsr_state;
    logic [7:0]  exp_frame [FRAME_BYTES];
    realtime     last_start;
    realtime     release_edge;

    cal_telemetry_top dut (
        .*,
        .adc0 (adc[0]),
        .adc1 (adc[1]),
        .adc2 (adc[2]),
        .adc3 (adc[3]),
        .dac0 (dac[0]),
        .dac1 (dac[1]),
        .dac2 (dac[2]),
        .dac3 (dac[3])
    );

    uart_rx_model u_rx (
        .clk (clk),
        .rx  (tx)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Checks failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_eq(input string test_name, input logic [31:0] expected,
                            input logic [31:0] actual);
        if (actual !== expected) begin
            fail_run($sformatf("error %s: expected 0x%0h, actual 0x%0h",
                               test_name, expected, actual));
        end
    endtask

    // Galois LFSR, stepped once for every bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            val        = {val[30:0], lfsr_state[0]};
            lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? LFSR_TAPS : 32'h0);
        end
        return val;
    endfunction

    task automatic drive_random_inputs();
        @(posedge clk);
        #DRIVE_DLY;
        eeprom_mfg    = 8'(rand_bits(8));
        eeprom_dev    = 8'(rand_bits(8));
        eeprom_serial = rand_bits(32);
        jack          = 8'(rand_bits(8));
        for (int ch = 0; ch < NUM_CH; ch++) begin
            adc[ch] = SAMPLE_W'(rand_bits(SAMPLE_W));
            dac[ch] = SAMPLE_W'(rand_bits(SAMPLE_W));
        end
    endtask

    // Two rising edges in reset, tx has to idle high after each
    task automatic apply_reset(input string test_name);
        @(posedge clk);
        #DRIVE_DLY;
        rst = 1'b1;
        repeat (2) begin
            @(posedge clk);
            release_edge = $realtime;
            #DRIVE_DLY;
            check_eq({test_name, " tx idle in reset"}, 1'b1, tx);
        end
        rst = 1'b0;
    endtask

    // Expected frame from the inputs as driven now
    task automatic build_frame();
        exp_frame[0]        = MAGIC_HI;
        exp_frame[1]        = MAGIC_LO;
        exp_frame[IDX_MFG]  = eeprom_mfg;
        exp_frame[IDX_DEV]  = eeprom_dev;
        exp_frame[IDX_JACK] = jack;
        for (int k = 0; k < 4; k++) begin
            exp_frame[IDX_SERIAL + k] = eeprom_serial[31 - 8 * k -: 8];
        end
        for (int ch = 0; ch < NUM_CH; ch++) begin
            exp_frame[IDX_ADC0 + 2 * ch]     = adc[ch][SAMPLE_W-1 -: 8];
            exp_frame[IDX_ADC0 + 2 * ch + 1] = adc[ch][7:0];
            exp_frame[IDX_DAC0 + 2 * ch]     = dac[ch][SAMPLE_W-1 -: 8];
            exp_frame[IDX_DAC0 + 2 * ch + 1] = dac[ch][7:0];
        end
    endtask

    task automatic recv_byte(input string test_name, output logic [7:0] data);
        logic frame_err;
        logic timed_out;
        u_rx.get_byte(data, frame_err, timed_out, last_start);
        if (timed_out) begin
            fail_run({test_name, ": no start bit on tx before the timeout"});
        end
        if (frame_err) begin
            fail_run({test_name, ": framing error, start or stop bit at the wrong level"});
        end
    endtask

    // Stream positions first..last, wrapping over frames; start bits must follow closely
    task automatic recv_range(input string test_name, input int first, input int last);
        logic [7:0] data;
        realtime    prev_start;
        prev_start = 0.0;
        for (int i = first; i <= last; i++) begin
            recv_byte(test_name, data);
            check_eq($sformatf("%s byte %0d", test_name, i), exp_frame[i % FRAME_BYTES], data);
            if ((i > first) && (last_start - prev_start > (BYTE_CLKS + 1) * CLK_PERIOD)) begin
                fail_run($sformatf("%s: start bit of byte %0d came late", test_name, i));
            end
            prev_start = last_start;
        end
    endtask

    task automatic test_reset_idle();
        drive_random_inputs();
        apply_reset("test_reset_idle");
        build_frame();
        recv_range("test_reset_idle", 0, 0);
        // Start bit leaves two cycles after release, seen at the following falling edge
        check_eq("test_reset_idle start delay", 2 * CLK_PERIOD + CLK_PERIOD / 2,
                 int'(last_start - release_edge));
        recv_range("test_reset_idle", 1, 1);
    endtask

    task automatic test_frame_content();
        drive_random_inputs();
        apply_reset("test_frame_content");
        build_frame();
        recv_range("test_frame_content", 0, FRAME_BYTES - 1);
    endtask

    task automatic test_snapshot();
        drive_random_inputs();
        apply_reset("test_snapshot");
        build_frame();
        recv_range("test_snapshot", 0, 1);
        // Frame in flight keeps its old snapshot
        drive_random_inputs();
        recv_range("test_snapshot", 2, FRAME_BYTES - 1);
        build_frame();
        recv_range("test_snapshot", 0, FRAME_BYTES - 1);
    endtask

    task automatic test_back_to_back();
        drive_random_inputs();
        apply_reset("test_back_to_back");
        build_frame();
        recv_range("test_back_to_back", 0, 3 * FRAME_BYTES - 1);
    endtask

    task automatic test_signed_extremes();
        drive_random_inputs();
        adc[0] = 16'sh8000;
        adc[1] = 16'sh7fff;
        adc[2] = -16'sd1;
        dac[1] = -16'sd1;
        dac[2] = 16'sh8000;
        dac[3] = 16'sh7fff;
        apply_reset("test_signed_extremes");
        build_frame();
        recv_range("test_signed_extremes", 0, FRAME_BYTES - 1);
    endtask

    initial begin
        rst           = 1'b1;
        eeprom_mfg    = '0;
        eeprom_dev    = '0;
        eeprom_serial = '0;
        jack          = '0;
        for (int ch = 0; ch < NUM_CH; ch++) begin
            adc[ch] = '0;
            dac[ch] = '0;
        end
        lfsr_state = 32'hf03d04dc;
        test_reset_idle();
        test_frame_content();
        test_snapshot();
        test_back_to_back();
        test_signed_extremes();
        $display("All checks passed");
        $finish;
    end

endmodule

// ==== bench/uart_rx_model.sv ====
// ##################################################
// Behavioral UART receiver for the testbench
// get_byte waits for a start bit and samples mid-bit
// ##################################################

module uart_rx_model
    import cal_telemetry_pkg::*;
(
    input logic clk,
    input logic rx
);

    timeunit 1ns;
    timeprecision 1ps;

    // Start bit search gives up after 20 bit times
    localparam int START_TIMEOUT = 20 * CLKS_PER_BIT;

    // The line is sampled on falling clock edges, half a cycle away from tx updates
    task automatic get_byte(
        output logic [7:0] data,
        output logic       frame_err,
        output logic       timed_out,
        output realtime    start_time
    );
        logic prev;
        int   waited;
        data       = '0;
        frame_err  = 1'b0;
        timed_out  = 1'b1;
        start_time = 0.0;
        prev       = rx;
        waited     = 0;
        while (timed_out && (waited < START_TIMEOUT)) begin
            @(negedge clk);
            if (prev && !rx) begin
                timed_out  = 1'b0;
                start_time = $realtime;
            end
            prev   = rx;
            waited = waited + 1;
        end
        if (!timed_out) begin
            // Middle of the start bit
            repeat (CLKS_PER_BIT / 2) @(negedge clk);
            frame_err = rx;
            for (int i = 0; i < DATA_BITS; i++) begin
                repeat (CLKS_PER_BIT) @(negedge clk);
                data[i] = rx;
            end
            // Stop bit must be high
            repeat (CLKS_PER_BIT) @(negedge clk);
            frame_err = frame_err || !rx;
        end
    endtask

endmodule

// ==== cal_telemetry.f ====
verilog/cal_telemetry_pkg.sv
verilog/uart_tx.sv
verilog/cal_frame_sequencer.sv
verilog/cal_telemetry_top.sv
bench/uart_rx_model.sv
bench/cal_telemetry_tb.sv

// ==== verilog/cal_frame_sequencer.sv ====
// ##################################################
// Telemetry frame sequencer
// Snapshots inputs at frame start, feeds bytes to the UART
// ##################################################

module cal_frame_sequencer
    import cal_telemetry_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst,
    input  logic [7:0]                 eeprom_mfg,
    input  logic [7:0]                 eeprom_dev,
    input  logic [31:0]                eeprom_serial,
    input  logic [7:0]                 jack,
    input  logic signed [SAMPLE_W-1:0] adc0,
    input  logic signed [SAMPLE_W-1:0] adc1,
    input  logic signed [SAMPLE_W-1:0] adc2,
    input  logic signed [SAMPLE_W-1:0] adc3,
    input  logic signed [SAMPLE_W-1:0] dac0,
    input  logic signed [SAMPLE_W-1:0] dac1,
    input  logic signed [SAMPLE_W-1:0] dac2,
    input  logic signed [SAMPLE_W-1:0] dac3,
    input  logic                       tx_ack,
    output logic                       tx_valid,
    output logic [7:0]                 tx_data
);

    logic [IDX_W-1:0]           idx;
    logic                       snap_load;

    // Snapshot bank
    logic [7:0]                 mfg_snap;
    logic [7:0]                 dev_snap;
    logic [31:0]                serial_snap;
    logic [7:0]                 jack_snap;
    logic signed [SAMPLE_W-1:0] adc_snap [NUM_CH];
    logic signed [SAMPLE_W-1:0] dac_snap [NUM_CH];

    logic [IDX_W-1:0]           adc_off;
    logic [IDX_W-1:0]           dac_off;
    logic [IDX_W-1:0]           serial_off;
    logic signed [SAMPLE_W-1:0] sample;

    // Fresh snapshot on the first cycle out of reset and on every wrap to index 0
    assign snap_load = !tx_valid || (tx_ack && (idx == IDX_LAST));

    always_ff @(posedge clk) begin
        if (rst) begin
            idx      <= '0;
            tx_valid <= 1'b0;
        end else if (!tx_valid) begin
            idx      <= IDX_MAGIC_HI;
            tx_valid <= 1'b1;
        end else if (tx_ack) begin
            idx <= (idx == IDX_LAST) ? IDX_MAGIC_HI : idx + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (snap_load) begin
            mfg_snap    <= eeprom_mfg;
            dev_snap    <= eeprom_dev;
            serial_snap <= eeprom_serial;
            jack_snap   <= jack;
            adc_snap[0] <= adc0;
            adc_snap[1] <= adc1;
            adc_snap[2] <= adc2;
            adc_snap[3] <= adc3;
            dac_snap[0] <= dac0;
            dac_snap[1] <= dac1;
            dac_snap[2] <= dac2;
            dac_snap[3] <= dac3;
        end
    end

    assign adc_off    = idx - IDX_ADC0;
    assign dac_off    = idx - IDX_DAC0;
    assign serial_off = idx - IDX_SERIAL;

    // Pick the sample this index belongs to
    always_comb begin
        if (idx >= IDX_DAC0) begin
            sample = dac_snap[dac_off[CH_W:1]];
        end else begin
            sample = adc_snap[adc_off[CH_W:1]];
        end
    end

    always_comb begin
        case (idx)
            IDX_MAGIC_HI: tx_data = MAGIC_HI;
            IDX_MAGIC_LO: tx_data = MAGIC_LO;
            IDX_MFG:      tx_data = mfg_snap;
            IDX_DEV:      tx_data = dev_snap;
            IDX_SERIAL,
            IDX_SERIAL + IDX_W'(1),
            IDX_SERIAL + IDX_W'(2),
            IDX_SERIAL + IDX_W'(3): begin
                // MSB first
                tx_data = serial_snap[8*(3 - serial_off[1:0]) +: 8];
            end
            IDX_JACK:     tx_data = jack_snap;
            default: begin
                // Even offset is the high byte
                if (adc_off[0]) begin
                    tx_data = sample[7:0];
                end else begin
                    tx_data = sample[SAMPLE_W-1 -: 8];
                end
            end
        endcase
    end

    assert property (@(posedge clk) disable iff (rst)
        idx <= IDX_LAST);

    // Byte must hold until the serializer takes it
    assert property (@(posedge clk) disable iff (rst)
        (tx_valid && !tx_ack) |=> $stable(tx_data));

endmodule

// ==== verilog/cal_telemetry_pkg.sv ====
// ##################################################
// Shared constants for the calibration telemetry stream
// Frame layout, magic bytes, sample width, UART timing
// ##################################################

package cal_telemetry_pkg;

    // Sample format
    localparam int SAMPLE_W = 16;
    localparam int NUM_CH   = 4;
    localparam int CH_W     = $clog2(NUM_CH);

    // UART bit timing, 12 MHz clock gives 1 Mbaud
    localparam int CLKS_PER_BIT = 12;
    localparam int BAUD_CNT_W   = $clog2(CLKS_PER_BIT);
    localparam int DATA_BITS    = 8;
    // Start + data + stop
    localparam int UART_BITS    = DATA_BITS + 2;
    localparam int BIT_CNT_W    = $clog2(UART_BITS + 1);

    // Frame start marker
    localparam logic [7:0] MAGIC_HI = 8'hBE;
    localparam logic [7:0] MAGIC_LO = 8'hEF;

    // Frame layout
    localparam int FRAME_BYTES = 25;
    localparam int IDX_W       = $clog2(FRAME_BYTES);

    localparam logic [IDX_W-1:0] IDX_MAGIC_HI = IDX_W'(0);
    localparam logic [IDX_W-1:0] IDX_MAGIC_LO = IDX_W'(1);
    localparam logic [IDX_W-1:0] IDX_MFG      = IDX_W'(2);
    localparam logic [IDX_W-1:0] IDX_DEV      = IDX_W'(3);
    // Serial number, MSB first over four bytes
    localparam logic [IDX_W-1:0] IDX_SERIAL   = IDX_W'(4);
    localparam logic [IDX_W-1:0] IDX_JACK     = IDX_W'(8);
    // Each sample takes two indices, high byte first
    localparam logic [IDX_W-1:0] IDX_ADC0     = IDX_W'(9);
    localparam logic [IDX_W-1:0] IDX_DAC0     = IDX_W'(17);
    localparam logic [IDX_W-1:0] IDX_LAST     = IDX_W'(FRAME_BYTES - 1);

endpackage

// ==== verilog/cal_telemetry_top.sv ====
// ##################################################
// Calibration telemetry top level
// Streams snapshot frames of the inputs out of tx
// ##################################################

module cal_telemetry_top
    import cal_telemetry_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst,
    input  logic [7:0]                 eeprom_mfg,
    input  logic [7:0]                 eeprom_dev,
    input  logic [31:0]                eeprom_serial,
    input  logic [7:0]                 jack,
    input  logic signed [SAMPLE_W-1:0] adc0,
    input  logic signed [SAMPLE_W-1:0] adc1,
    input  logic signed [SAMPLE_W-1:0] adc2,
    input  logic signed [SAMPLE_W-1:0] adc3,
    input  logic signed [SAMPLE_W-1:0] dac0,
    input  logic signed [SAMPLE_W-1:0] dac1,
    input  logic signed [SAMPLE_W-1:0] dac2,
    input  logic signed [SAMPLE_W-1:0] dac3,
    output logic                       tx
);

    // Byte handshake between sequencer and serializer
    logic       tx_valid;
    logic       tx_ack;
    logic [7:0] tx_data;

    cal_frame_sequencer u_seq (
        .clk           (clk),
        .rst           (rst),
        .eeprom_mfg    (eeprom_mfg),
        .eeprom_dev    (eeprom_dev),
        .eeprom_serial (eeprom_serial),
        .jack          (jack),
        .adc0          (adc0),
        .adc1          (adc1),
        .adc2          (adc2),
        .adc3          (adc3),
        .dac0          (dac0),
        .dac1          (dac1),
        .dac2          (dac2),
        .dac3          (dac3),
        .tx_ack        (tx_ack),
        .tx_valid      (tx_valid),
        .tx_data       (tx_data)
    );

    uart_tx u_tx (
        .clk      (clk),
        .rst      (rst),
        .tx_valid (tx_valid),
        .tx_data  (tx_data),
        .tx_ack   (tx_ack),
        .tx       (tx)
    );

endmodule

// ==== verilog/uart_tx.sv ====
// ##################################################
// 8N1 UART serializer with a valid/ack byte handshake
// Back-to-back bytes are sent with no idle gap
// ##################################################

module uart_tx
    import cal_telemetry_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       tx_valid,
    input  logic [7:0] tx_data,
    output logic       tx_ack,
    output logic       tx
);

    logic                  busy;
    logic [BAUD_CNT_W-1:0] baud_cnt;
    logic [BIT_CNT_W-1:0]  bit_cnt;
    logic [7:0]            shift;
    logic                  bit_end;
    logic                  frame_end;
    logic                  in_data;

    assign bit_end   = (baud_cnt == BAUD_CNT_W'(CLKS_PER_BIT - 1));
    assign frame_end = busy && bit_end && (bit_cnt == BIT_CNT_W'(UART_BITS - 1));

    // Start bit and data bits 0..6 are followed by another data bit
    assign in_data = (bit_cnt < BIT_CNT_W'(DATA_BITS));

    // Accept when idle, or on the last cycle of the stop bit
    assign tx_ack = tx_valid && (!busy || frame_end);

    always_ff @(posedge clk) begin
        if (rst) begin
            busy     <= 1'b0;
            baud_cnt <= '0;
            bit_cnt  <= '0;
            tx       <= 1'b1;
        end else if (tx_ack) begin
            // Begin start bit
            busy     <= 1'b1;
            baud_cnt <= '0;
            bit_cnt  <= '0;
            tx       <= 1'b0;
        end else if (busy) begin
            if (bit_end) begin
                baud_cnt <= '0;
                bit_cnt  <= bit_cnt + 1'b1;
                if (in_data) begin
                    tx <= shift[0];
                end else if (bit_cnt == BIT_CNT_W'(DATA_BITS)) begin
                    // Stop bit
                    tx <= 1'b1;
                end else begin
                    busy <= 1'b0;
                end
            end else begin
                baud_cnt <= baud_cnt + 1'b1;
            end
        end
    end

    // Data shifts out LSB first
    always_ff @(posedge clk) begin
        if (tx_ack) begin
            shift <= tx_data;
        end else if (busy && bit_end && in_data) begin
            shift <= shift >> 1;
        end
    end

    // A new byte cannot be accepted before a full byte time has passed
    assert property (@(posedge clk) disable iff (rst)
        tx_ack |=> !tx_ack);

    // Line idles high out of reset
    assert property (@(posedge clk) rst |=> tx);

endmodule
